/* flist.f */
+incdir+verif
common/branch_pkg.sv
rtl/branch_decode.sv
branch_unit/branch_unit.sv
rtl/branch_resolve.sv
rtl/return_stack.sv
rtl/branch_top.sv
verif/branch_tb.sv

/* verif/branch_tb_table.svh */
`ifndef BRANCH_TB_TABLE_SVH
`define BRANCH_TB_TABLE_SVH

// Each row holds pc, instruction, rs1, rs2, followed_pc, flags, redirect_pc and ras_top
// Flag bits from the top are valid flush taken tr_branch tr_return ras_valid
task automatic load_table();
    // Six conditions, BLT and BLTU split on the sign bit
    add_row('h100, enc_b(branch_pkg::FN3_BEQ, 'h0040), 'h5, 'h5, 'h140, 6'b101000, 'h140, 0);
    add_row('h200, enc_b(branch_pkg::FN3_BNE, 'h0020), 'h5, 'h5, 'h220, 6'b110100, 'h204, 0);
    add_row('h300, enc_b(branch_pkg::FN3_BLT, 'h0010), 'hffffffff, 'h1, 'h304,
            6'b111100, 'h310, 0);
    add_row('h400, enc_b(branch_pkg::FN3_BLTU, 'h0010), 'hffffffff, 'h1, 'h404,
            6'b100000, 'h404, 0);
    // Backward targets, min int against max int
    add_row('h500, enc_b(branch_pkg::FN3_BGE, 'h1fe0), 'h80000000, 'h7fffffff, 'h504,
            6'b100000, 'h504, 0);
    add_row('h600, enc_b(branch_pkg::FN3_BGEU, 'h1fe0), 'h80000000, 'h7fffffff, 'h604,
            6'b111100, 'h5e0, 0);
    // ADDI in the middle of the stream
    add_row('h700, 'h00000013, 'h1, 'h2, 'h704, 6'b000000, 0, 0);
    // Call, then a mispredicted return
    add_row('h1000, enc_jal(5'd1, 'h800), 0, 0, 'h1800, 6'b101001, 'h1800, 'h1004);
    add_row('h1800, enc_jalr(5'd0, 5'd1, 'h0), 'h1004, 0, 'h2000, 6'b111010, 'h1004, 0);
    // JALR call with odd sum
    add_row('h1100, enc_jalr(5'd5, 5'd6, 'h4), 'h3001, 0, 'h3000, 6'b111101, 'h3004, 'h1104);
    add_row('h1200, enc_jal(5'd1, 'h100), 0, 0, 'h1300, 6'b101001, 'h1300, 'h1204);
    add_row('h1300, enc_jalr(5'd0, 5'd1, 'h0), 'h1204, 0, 'h1204, 6'b101001, 'h1204, 'h1104);
    add_row('h1400, enc_jalr(5'd0, 5'd5, 'h0), 'h1104, 0, 'h1104, 6'b101000, 'h1104, 0);
    // Five calls overflow the four entries
    add_row('h2000, enc_jal(5'd1, 'h8), 0, 0, 'h2008, 6'b101001, 'h2008, 'h2004);
    add_row('h2100, enc_jal(5'd1, 'h8), 0, 0, 'h2108, 6'b101001, 'h2108, 'h2104);
    add_row('h2200, enc_jal(5'd1, 'h8), 0, 0, 'h2208, 6'b101001, 'h2208, 'h2204);
    add_row('h2300, enc_jal(5'd1, 'h8), 0, 0, 'h2308, 6'b101001, 'h2308, 'h2304);
    add_row('h2400, enc_jal(5'd1, 'h8), 0, 0, 'h2408, 6'b101001, 'h2408, 'h2404);
    // Four returns drain it
    add_row('h2500, enc_jalr(5'd0, 5'd1, 'h0), 'h2404, 0, 'h2404, 6'b101001, 'h2404, 'h2304);
    add_row('h2600, enc_jalr(5'd0, 5'd1, 'h0), 'h2304, 0, 'h2304, 6'b101001, 'h2304, 'h2204);
    add_row('h2700, enc_jalr(5'd0, 5'd1, 'h0), 'h2204, 0, 'h2204, 6'b101001, 'h2204, 'h2104);
    add_row('h2800, enc_jalr(5'd0, 5'd1, 'h0), 'h2104, 0, 'h2104, 6'b101000, 'h2104, 0);
endtask

`endif

/* verif/branch_tb.sv */
`timescale 1ns/1ps

module branch_tb;

    // One table row, stimulus then expectations
    typedef struct {
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] followed;
        logic [5:0]  flags;
        logic [31:0] redirect;
        logic [31:0] top;
    } row_t;

    logic                        clk;
    logic                        arst_n;
    branch_pkg::branch_issue_t   issue;
    branch_pkg::branch_resolve_t result;
    logic [31:0]                 ras_top;
    logic                        ras_valid;
    logic                        tr_branch_mispredict;
    logic                        tr_return_mispredict;

    row_t rows[$];
    // Row tag per observed cycle, -1 when idle
    int   tag_q[$];
    int   cur_tag        = -1;
    int   ras_tag        = -1;
    int   ras_done       = 0;
    int   valid_seen     = 0;
    int   valid_expected = 0;
    int   checks         = 0;
    int   value_errors   = 0;
    int   other_errors   = 0;

    branch_top UUT (
        .clk                  (clk),
        .arst_n               (arst_n),
        .issue                (issue),
        .result               (result),
        .ras_top              (ras_top),
        .ras_valid            (ras_valid),
        .tr_branch_mispredict (tr_branch_mispredict),
        .tr_return_mispredict (tr_return_mispredict)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // RV32I encoders

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, branch_pkg::OPC_JAL};
    endfunction

    function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, branch_pkg::OPC_JALR};
    endfunction

    // Register fields x10 and x11, only values matter
    function automatic logic [31:0] enc_b(input logic [2:0] fn3, input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd11, 5'd10, fn3, imm[4:1], imm[11],
                branch_pkg::OPC_BRANCH};
    endfunction

    task automatic add_row(input logic [31:0] pc, input logic [31:0] instr,
                           input logic [31:0] rs1, input logic [31:0] rs2,
                           input logic [31:0] followed, input logic [5:0] flags,
                           input logic [31:0] redirect, input logic [31:0] top);
        row_t r;
        r = '{pc, instr, rs1, rs2, followed, flags, redirect, top};
        rows.push_back(r);
    endtask

    `include "branch_tb_table.svh"

    ////////////////////////////////////////////////////////////////////////////
    // Scoreboard

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    // Resolve outputs for the row issued three edges back
    task automatic check_result(input int t);
        logic [5:0]  f;
        logic [31:0] redir;
        f     = '0;
        redir = '0;
        if (t >= 0) begin
            f     = rows[t].flags;
            redir = rows[t].redirect;
        end
        check_value("result.valid", result.valid, f[5]);
        check_value("result.flush", result.flush, f[4]);
        check_value("tr_branch_mispredict", tr_branch_mispredict, f[2]);
        check_value("tr_return_mispredict", tr_return_mispredict, f[1]);
        if (f[5]) begin
            check_value("result.taken", result.taken, f[3]);
            check_value("result.redirect_pc", result.redirect_pc, redir);
        end
    endtask

    // Stack top lags the result by one cycle
    task automatic check_stack(input int t);
        check_value("ras_valid", ras_valid, rows[t].flags[0]);
        if (rows[t].flags[0]) begin
            check_value("ras_top", ras_top, rows[t].top);
        end
    endtask

    task automatic observe_cycle();
        int t;
        if (result.valid) begin
            valid_seen++;
        end
        if (ras_tag >= 0) begin
            check_stack(ras_tag);
            ras_done++;
        end
        ras_tag = -1;
        tag_q.push_back(cur_tag);
        if (tag_q.size() > 3) begin
            t = tag_q.pop_front();
            check_result(t);
            ras_tag = t;
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (arst_n) begin
            observe_cycle();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    initial begin
        int wait_cyc;
        arst_n = 1'b0;
        issue  = '0;
        load_table();
        foreach (rows[i]) begin
            valid_expected += rows[i].flags[5];
        end
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        // One row per edge, back to back
        foreach (rows[i]) begin
            @(posedge clk);
            issue <= '{valid: 1'b1, pc: rows[i].pc, instruction: rows[i].instr,
                       rs1: rows[i].rs1, rs2: rows[i].rs2,
                       followed_pc: rows[i].followed};
            cur_tag <= i;
        end
        @(posedge clk);
        issue   <= '0;
        cur_tag <= -1;
        // Drain until the last stack check
        wait_cyc = 0;
        while (ras_done < rows.size() && wait_cyc < 40) begin
            @(posedge clk);
            wait_cyc++;
        end
        if (ras_done < rows.size()) begin
            $display("Timed out waiting for the last branch result to come out of the DUT");
            other_errors++;
        end
        check_value("result count", valid_seen, valid_expected);
        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* rtl/branch_top.sv */
`timescale 1ns/1ps

module branch_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  branch_pkg::branch_issue_t   issue,
    output branch_pkg::branch_resolve_t result,
    output logic [31:0]                 ras_top,
    output logic                        ras_valid,
    output logic                        tr_branch_mispredict,
    output logic                        tr_return_mispredict
);

    // Inter-stage payloads
    branch_pkg::branch_dec_t dec;
    branch_pkg::branch_ex_t  ex;

    // Resolve to stack
    logic        push;
    logic        pop;
    logic [31:0] push_addr;

    ////////////////////////////////////////////////////////////////////////////
    // Decode, execute, resolve, then the stack

    branch_decode u_decode (
        .clk    (clk),
        .arst_n (arst_n),
        .issue  (issue),
        .dec    (dec)
    );

    branch_unit u_unit (
        .clk    (clk),
        .arst_n (arst_n),
        .dec    (dec),
        .ex     (ex)
    );

    branch_resolve u_resolve (
        .clk                  (clk),
        .arst_n               (arst_n),
        .ex                   (ex),
        .result               (result),
        .push                 (push),
        .pop                  (pop),
        .push_addr            (push_addr),
        .tr_branch_mispredict (tr_branch_mispredict),
        .tr_return_mispredict (tr_return_mispredict)
    );

    // ras_top lags the resolve outputs by one cycle
    return_stack u_ras (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (push),
        .pop       (pop),
        .push_addr (push_addr),
        .ras_top   (ras_top),
        .ras_valid (ras_valid)
    );

endmodule

/* rtl/return_stack.sv */
`timescale 1ns/1ps

module return_stack (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        push,
    input  logic        pop,
    input  logic [31:0] push_addr,
    output logic [31:0] ras_top,
    output logic        ras_valid
);

    // Circular storage
    logic [31:0]                      entries [branch_pkg::RAS_DEPTH];
    logic [branch_pkg::RAS_PTR_W-1:0] top_ptr;
    logic [branch_pkg::RAS_PTR_W-1:0] push_ptr;

    // Occupancy, one bit wider than the pointer
    logic [branch_pkg::RAS_PTR_W:0]   count;
    logic                             full;
    logic                             do_pop;

    // Pointer wraps naturally at a power-of-two depth
    assign push_ptr = top_ptr + 1'b1;
    assign full     = (count == branch_pkg::RAS_DEPTH);
    // Empty pop has no effect
    assign do_pop   = pop && (count != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            top_ptr <= '0;
            count   <= '0;
        end else if (push) begin
            top_ptr <= push_ptr;
            // Full push lands on the oldest slot, count saturates
            if (!full) begin
                count <= count + 1'b1;
            end
        end else if (do_pop) begin
            top_ptr <= top_ptr - 1'b1;
            count   <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[push_ptr] <= push_addr;
        end
    end

    assign ras_top   = entries[top_ptr];
    assign ras_valid = (count != '0);

    a_count_bound: assert property (
        @(posedge clk) disable iff (!arst_n)
        count <= branch_pkg::RAS_DEPTH
    );

endmodule

/* rtl/branch_resolve.sv */
`timescale 1ns/1ps

module branch_resolve (
    input  logic                        clk,
    input  logic                        arst_n,
    input  branch_pkg::branch_ex_t      ex,
    output branch_pkg::branch_resolve_t result,
    output logic                        push,
    output logic                        pop,
    output logic [31:0]                 push_addr,
    output logic                        tr_branch_mispredict,
    output logic                        tr_return_mispredict
);

    // Where the instruction really goes
    logic [31:0] real_pc;
    logic        mispredict;

    // Result register
    logic        valid_q;
    logic        taken_q;
    logic        flush_q;
    logic [31:0] redirect_q;

    assign real_pc = ex.taken ? ex.jump_pc : ex.njump_pc;

    // Bit 0 ignored, fetch never sets it meaningfully
    assign mispredict = ex.valid && (real_pc[31:1] != ex.followed_pc[31:1]);

    ////////////////////////////////////////////////////////////////////////////
    // Control strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q              <= 1'b0;
            taken_q              <= 1'b0;
            flush_q              <= 1'b0;
            push                 <= 1'b0;
            pop                  <= 1'b0;
            tr_branch_mispredict <= 1'b0;
            tr_return_mispredict <= 1'b0;
        end else begin
            valid_q              <= ex.valid;
            taken_q              <= ex.valid & ex.taken;
            flush_q              <= mispredict;
            // Stack follows call / return marks
            push                 <= ex.valid & ex.is_call;
            pop                  <= ex.valid & ex.is_return;
            // Trace split by return
            tr_branch_mispredict <= mispredict & ~ex.is_return;
            tr_return_mispredict <= mispredict & ex.is_return;
        end
    end

    // Addresses
    always_ff @(posedge clk) begin
        redirect_q <= real_pc;
        push_addr  <= ex.njump_pc;
    end

    always_comb begin
        result.valid       = valid_q;
        result.taken       = taken_q;
        result.flush       = flush_q;
        result.redirect_pc = redirect_q;
    end

    // Decode never marks one instruction as both call and return
    a_push_pop_excl: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(push && pop)
    );

endmodule

/* branch_unit/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
    input  logic                    clk,
    input  logic                    arst_n,
    input  branch_pkg::branch_dec_t dec,
    output branch_pkg::branch_ex_t  ex
);

    // Comparator outputs
    logic        eq;
    logic        lt_s;
    logic        lt_u;
    logic        cmp;
    logic        taken_next;

    // Target arithmetic
    logic [31:0] jump_base;
    logic [31:0] jump_sum;

    // Stage register
    branch_pkg::branch_ex_t ex_next;
    branch_pkg::branch_ex_t ex_q;
    logic                   valid_q;

    ////////////////////////////////////////////////////////////////////////////
    // Condition evaluation

    assign eq   = (dec.rs1 == dec.rs2);
    assign lt_s = ($signed(dec.rs1) < $signed(dec.rs2));
    assign lt_u = (dec.rs1 < dec.rs2);

    // Base relation, fn3 bit 0 flips it afterwards
    always_comb begin
        case (dec.fn3)
            branch_pkg::FN3_BEQ, branch_pkg::FN3_BNE: begin
                cmp = eq;
            end
            branch_pkg::FN3_BLT, branch_pkg::FN3_BGE: begin
                cmp = lt_s;
            end
            branch_pkg::FN3_BLTU, branch_pkg::FN3_BGEU: begin
                cmp = lt_u;
            end
            default: begin
                cmp = eq;
            end
        endcase
    end

    // JAL / JALR always taken
    assign taken_next = dec.is_branch ? (cmp ^ dec.fn3[0]) : 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // Targets

    // JALR is register relative, the rest pc relative
    assign jump_base = dec.is_jalr ? dec.rs1 : dec.pc;
    assign jump_sum  = jump_base + dec.offset;

    always_comb begin
        ex_next.valid       = dec.valid;
        ex_next.taken       = taken_next;
        ex_next.is_call     = dec.is_call;
        ex_next.is_return   = dec.is_return;
        // Bit 0 dropped as the ISA demands for JALR
        ex_next.jump_pc     = {jump_sum[31:1], 1'b0};
        ex_next.njump_pc    = dec.pc + 32'd4;
        ex_next.followed_pc = dec.followed_pc;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= ex_next.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_q <= ex_next;
    end

    always_comb begin
        ex       = ex_q;
        ex.valid = valid_q;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    // Decode must hand over exactly one kind per valid instruction
    a_kind_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        dec.valid |-> $onehot({dec.is_jal, dec.is_jalr, dec.is_branch})
    );

endmodule

/* rtl/branch_decode.sv */
`timescale 1ns/1ps

module branch_decode (
    input  logic                      clk,
    input  logic                      arst_n,
    input  branch_pkg::branch_issue_t issue,
    output branch_pkg::branch_dec_t   dec
);

    // Raw instruction fields
    logic [6:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1_idx;

    // rd / rs1 name a link register
    logic        rd_link;
    logic        rs1_link;

    // Immediates, LSB zero already appended for J and B
    logic [20:0] j_imm;
    logic [11:0] i_imm;
    logic [12:0] b_imm;

    // Stage register
    branch_pkg::branch_dec_t dec_next;
    branch_pkg::branch_dec_t dec_q;
    logic                    valid_q;

    assign opcode  = issue.instruction[6:0];
    assign rd      = issue.instruction[11:7];
    assign rs1_idx = issue.instruction[19:15];

    assign rd_link  = (rd == branch_pkg::REG_RA) || (rd == branch_pkg::REG_T0);
    assign rs1_link = (rs1_idx == branch_pkg::REG_RA) || (rs1_idx == branch_pkg::REG_T0);

    // Scattered immediate bits
    assign j_imm = {issue.instruction[31], issue.instruction[19:12],
                    issue.instruction[20], issue.instruction[30:21], 1'b0};
    assign i_imm = issue.instruction[31:20];
    assign b_imm = {issue.instruction[31], issue.instruction[7],
                    issue.instruction[30:25], issue.instruction[11:8], 1'b0};

    ////////////////////////////////////////////////////////////////////////////
    // Classification
    always_comb begin
        dec_next.is_jal    = (opcode == branch_pkg::OPC_JAL);
        dec_next.is_jalr   = (opcode == branch_pkg::OPC_JALR);
        dec_next.is_branch = (opcode == branch_pkg::OPC_BRANCH);
        // Anything else is not ours
        dec_next.valid = issue.valid &
                         (dec_next.is_jal | dec_next.is_jalr | dec_next.is_branch);
        // Call wins over return when both match
        dec_next.is_call   = (dec_next.is_jal | dec_next.is_jalr) & rd_link;
        dec_next.is_return = dec_next.is_jalr & rs1_link & ~rd_link;
        dec_next.fn3         = issue.instruction[14:12];
        dec_next.pc          = issue.pc;
        dec_next.rs1         = issue.rs1;
        dec_next.rs2         = issue.rs2;
        dec_next.followed_pc = issue.followed_pc;
        // One sign-extended offset per kind
        if (dec_next.is_jal) begin
            dec_next.offset = 32'(signed'(j_imm));
        end else if (dec_next.is_jalr) begin
            dec_next.offset = 32'(signed'(i_imm));
        end else begin
            dec_next.offset = 32'(signed'(b_imm));
        end
    end

    // Stage valid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= dec_next.valid;
        end
    end

    always_ff @(posedge clk) begin
        dec_q <= dec_next;
    end

    always_comb begin
        dec       = dec_q;
        dec.valid = valid_q;
    end

endmodule

/* common/branch_pkg.sv */
package branch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // RV32I encodings seen by the branch path

    // Major opcodes
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Conditional branch funct3
    localparam logic [2:0] FN3_BEQ  = 3'b000;
    localparam logic [2:0] FN3_BNE  = 3'b001;
    localparam logic [2:0] FN3_BLT  = 3'b100;
    localparam logic [2:0] FN3_BGE  = 3'b101;
    localparam logic [2:0] FN3_BLTU = 3'b110;
    localparam logic [2:0] FN3_BGEU = 3'b111;

    // Link registers per the calling convention (ra and t0)
    localparam logic [4:0] REG_RA = 5'd1;
    localparam logic [4:0] REG_T0 = 5'd5;

    // Return stack sizing, power of two from 2 to 16
    localparam int RAS_DEPTH = 4;
    localparam int RAS_PTR_W = $clog2(RAS_DEPTH);

    ////////////////////////////////////////////////////////////////////////////
    // Stage payloads

    // From issue
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instruction;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] followed_pc;
    } branch_issue_t;

    // Decode to execute
    typedef struct packed {
        logic        valid;
        logic        is_jal;
        logic        is_jalr;
        logic        is_branch;
        logic        is_call;
        logic        is_return;
        logic [2:0]  fn3;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] followed_pc;
        logic [31:0] offset;
    } branch_dec_t;

    // Execute to resolve
    typedef struct packed {
        logic        valid;
        logic        taken;
        logic        is_call;
        logic        is_return;
        logic [31:0] jump_pc;
        logic [31:0] njump_pc;
        logic [31:0] followed_pc;
    } branch_ex_t;

    // Resolve result to the core
    typedef struct packed {
        logic        valid;
        logic        taken;
        logic        flush;
        logic [31:0] redirect_pc;
    } branch_resolve_t;

endpackage
